// ==== Bender.yml ====
package:
  name: xbar

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/xbar_pkg.sv
      - hdl/xbar_addr_decode.sv
      - hdl/xbar_txn_fsm.sv
      - hdl/xbar_route.sv
      - hdl/xbar_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/xbar_slave_model.sv
      - sim/tb_xbar.sv

// ==== hdl/xbar_addr_decode.sv ====
`timescale 1ns/1ps
`include "xbar_defs.svh"

module xbar_addr_decode (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`XBAR_ADDR_W-1:0] araddr,
    input  logic [`XBAR_ADDR_W-1:0] awaddr,
    input  logic                    rd_sel,
    input  logic                    decode_load,
    output xbar_pkg::xbar_target_e  target
);
    import xbar_pkg::*;

    logic [`XBAR_ADDR_W-1:0] sel_addr;
    xbar_target_e            target_d;

    assign sel_addr = rd_sel ? araddr : awaddr;

    // anything but an exact match falls to sram
    always_comb begin
        case (sel_addr)
            `XBAR_UART_BASE:      target_d = tgt_uart;
            `XBAR_CLINT_BASE,
            `XBAR_CLINT_BASE + 4: target_d = tgt_clint;
            default:              target_d = tgt_sram;
        endcase
    end

    // held until the next transaction loads
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            target <= tgt_none;
        end else if (decode_load) begin
            target <= target_d;
        end
    end

    // the slave chosen on the load edge is a real port
    a_target_onehot: assert property (
        @(posedge clk) disable iff (rst)
        decode_load |=> $onehot(target)
    ) else $error("xbar_addr_decode: target not one-hot after load");

endmodule

// ==== hdl/xbar_defs.svh ====
`ifndef XBAR_DEFS_SVH
`define XBAR_DEFS_SVH

// bus widths
`define XBAR_ADDR_W 32
`define XBAR_DATA_W 32

// uart register is a single word
`define XBAR_UART_BASE 32'ha000_03f8

// clint occupies this word and the next one
`define XBAR_CLINT_BASE 32'ha000_0048

`endif

// ==== hdl/xbar_pkg.sv ====
`include "xbar_defs.svh"

package xbar_pkg;

    // master to slave
    typedef struct packed {
        logic [`XBAR_ADDR_W-1:0]   awaddr;
        logic                      awvalid;
        logic [`XBAR_DATA_W-1:0]   wdata;
        logic [`XBAR_DATA_W/8-1:0] wstrb;
        logic                      wvalid;
        logic                      bready;
        logic [`XBAR_ADDR_W-1:0]   araddr;
        logic                      arvalid;
        logic                      rready;
    } axi_lite_req_t;

    // slave to master
    typedef struct packed {
        logic                    awready;
        logic                    wready;
        logic                    bvalid;
        logic [1:0]              bresp;
        logic                    arready;
        logic                    rvalid;
        logic [`XBAR_DATA_W-1:0] rdata;
        logic [1:0]              rresp;
    } axi_lite_rsp_t;

    typedef enum logic [2:0] {
        st_idle        = 3'd0,
        st_addr_decode = 3'd1,
        st_xfer_rd     = 3'd2,
        st_xfer_wr     = 3'd3,
        st_resp_rd     = 3'd4,
        st_resp_wr     = 3'd5
    } xbar_state_e;

    // bit k selects slave port k
    typedef enum logic [2:0] {
        tgt_none  = 3'b000, // only seen after reset
        tgt_sram  = 3'b001,
        tgt_uart  = 3'b010,
        tgt_clint = 3'b100
    } xbar_target_e;

endpackage

// ==== hdl/xbar_route.sv ====
`timescale 1ns/1ps

module xbar_route (
    input  xbar_pkg::xbar_state_e   state,
    input  xbar_pkg::xbar_target_e  target,
    input  xbar_pkg::axi_lite_req_t mst_req,
    output xbar_pkg::axi_lite_rsp_t mst_rsp,
    output xbar_pkg::axi_lite_req_t slv_req [3],
    input  xbar_pkg::axi_lite_rsp_t slv_rsp [3],
    output logic                    rsp_done
);
    import xbar_pkg::*;

    logic [2:0] tgt_bits;
    logic       fwd_rd;    // read address channel open
    logic       fwd_wr;    // write address and data open
    logic [2:0] slv_valid;

    assign tgt_bits = target;

    // in decode the read is preferred as in the fsm
    assign fwd_rd = (state == st_xfer_rd) ||
                    ((state == st_addr_decode) && mst_req.arvalid);
    assign fwd_wr = (state == st_xfer_wr) ||
                    ((state == st_addr_decode) && !mst_req.arvalid);

    always_comb begin
        mst_rsp = '0;
        for (int k = 0; k < 3; k++) begin
            slv_req[k]         = mst_req; // addr and data broadcast
            slv_req[k].arvalid = 1'b0;
            slv_req[k].awvalid = 1'b0;
            slv_req[k].wvalid  = 1'b0;
            slv_req[k].rready  = 1'b0;
            slv_req[k].bready  = 1'b0;
            if (tgt_bits[k]) begin
                if (fwd_rd) begin
                    slv_req[k].arvalid = mst_req.arvalid;
                    mst_rsp.arready    = slv_rsp[k].arready;
                end
                if (fwd_wr) begin
                    slv_req[k].awvalid = mst_req.awvalid;
                    slv_req[k].wvalid  = mst_req.wvalid;
                    mst_rsp.awready    = slv_rsp[k].awready;
                    mst_rsp.wready     = slv_rsp[k].wready;
                end
                if (state == st_xfer_rd) begin
                    slv_req[k].rready = mst_req.rready;
                    mst_rsp.rvalid    = slv_rsp[k].rvalid;
                    mst_rsp.rdata     = slv_rsp[k].rdata;
                    mst_rsp.rresp     = slv_rsp[k].rresp;
                end
                if (state == st_xfer_wr) begin
                    slv_req[k].bready = mst_req.bready;
                    mst_rsp.bvalid    = slv_rsp[k].bvalid;
                    mst_rsp.bresp     = slv_rsp[k].bresp;
                end
            end
        end
    end

    // response handshake seen on the master side
    assign rsp_done = ((state == st_xfer_rd) && mst_rsp.rvalid && mst_req.rready) ||
                      ((state == st_xfer_wr) && mst_rsp.bvalid && mst_req.bready);

    always_comb begin
        for (int k = 0; k < 3; k++) begin
            slv_valid[k] = slv_req[k].arvalid | slv_req[k].awvalid | slv_req[k].wvalid;
        end
        // payload goes everywhere, but only one slave is addressed
        a_one_slave: assert final ($onehot0(slv_valid))
            else $error("xbar_route: valid raised on more than one slave");
    end

endmodule

// ==== hdl/xbar_top.sv ====
`timescale 1ns/1ps

module xbar_top (
    input  logic                    clk,
    input  logic                    rst,
    input  xbar_pkg::axi_lite_req_t mst_req,
    output xbar_pkg::axi_lite_rsp_t mst_rsp,
    output xbar_pkg::axi_lite_req_t slv_req [3],
    input  xbar_pkg::axi_lite_rsp_t slv_rsp [3]
);
    import xbar_pkg::*;

    xbar_state_e  state;
    xbar_target_e target;
    logic         decode_load;
    logic         rd_sel;
    logic         rsp_done;

    xbar_txn_fsm u_fsm (
        .clk         (clk),
        .rst         (rst),
        .mst_arvalid (mst_req.arvalid),
        .mst_awvalid (mst_req.awvalid),
        .rsp_done    (rsp_done),
        .state       (state),
        .decode_load (decode_load),
        .rd_sel      (rd_sel)
    );

    xbar_addr_decode u_decode (
        .clk         (clk),
        .rst         (rst),
        .araddr      (mst_req.araddr),
        .awaddr      (mst_req.awaddr),
        .rd_sel      (rd_sel),
        .decode_load (decode_load),
        .target      (target)
    );

    // slave 0 sram, 1 uart, 2 clint
    xbar_route u_route (
        .state    (state),
        .target   (target),
        .mst_req  (mst_req),
        .mst_rsp  (mst_rsp),
        .slv_req  (slv_req),
        .slv_rsp  (slv_rsp),
        .rsp_done (rsp_done)
    );

endmodule

// ==== hdl/xbar_txn_fsm.sv ====
`timescale 1ns/1ps

module xbar_txn_fsm (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  mst_arvalid,
    input  logic                  mst_awvalid,
    input  logic                  rsp_done,
    output xbar_pkg::xbar_state_e state,
    output logic                  decode_load,
    output logic                  rd_sel
);
    import xbar_pkg::*;

    xbar_state_e next_state;
    logic        rd_q; // read chosen for this transaction

    assign decode_load = (state == st_idle) && (mst_arvalid || mst_awvalid);

    // follows arvalid in idle so the decoder has it on the load edge
    assign rd_sel = (state == st_idle) ? mst_arvalid : rd_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
            rd_q  <= 1'b0;
        end else begin
            state <= next_state;
            if (decode_load) begin
                rd_q <= mst_arvalid; // read wins when both are up
            end
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (decode_load) begin
                    next_state = st_addr_decode;
                end
            end
            st_addr_decode: begin
                next_state = rd_q ? st_xfer_rd : st_xfer_wr;
            end
            st_xfer_rd: begin
                if (rsp_done) begin
                    next_state = st_resp_rd;
                end
            end
            st_xfer_wr: begin
                if (rsp_done) begin
                    next_state = st_resp_wr;
                end
            end
            st_resp_rd, st_resp_wr: begin
                next_state = st_idle; // one quiet cycle
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    // no transfer is dropped straight back to idle
    a_rd_exit: assert property (
        @(posedge clk) disable iff (rst)
        (state == st_xfer_rd) |=> (state inside {st_xfer_rd, st_resp_rd})
    ) else $error("xbar_txn_fsm: read transfer left without resp_rd");

    a_wr_exit: assert property (
        @(posedge clk) disable iff (rst)
        (state == st_xfer_wr) |=> (state inside {st_xfer_wr, st_resp_wr})
    ) else $error("xbar_txn_fsm: write transfer left without resp_wr");

endmodule

// ==== project.f ====
+incdir+hdl
hdl/xbar_pkg.sv
hdl/xbar_addr_decode.sv
hdl/xbar_txn_fsm.sv
hdl/xbar_route.sv
hdl/xbar_top.sv
sim/xbar_slave_model.sv
sim/tb_xbar.sv

// ==== sim/tb_xbar.sv ====
`timescale 1ns/1ps
`include "xbar_defs.svh"

module tb_xbar;
    import xbar_pkg::*;

    localparam int cycle_limit = 200 * 40;
    localparam logic [31:0] tag_sram  = 32'h5a5a_0001;
    localparam logic [31:0] tag_uart  = 32'hc3c3_0002;
    localparam logic [31:0] tag_clint = 32'h0ff0_0004;

    logic          clk;
    logic          rst;
    axi_lite_req_t mst_req;
    axi_lite_rsp_t mst_rsp;
    axi_lite_req_t slv_req [3];
    axi_lite_rsp_t slv_rsp [3];

    integer      seed;
    int          errors;
    int          txns;
    int          cycles;
    string       test_name;
    logic [31:0] exp_rdata;
    int          exp_wr_slave;
    logic [31:0] store_m [3]; // expected slave contents
    logic        rd_pend;
    logic        wr_pend;
    logic        req_seen;
    logic [2:0]  slv_aw;
    logic [2:0]  slv_any;

    xbar_top DUT (
        .clk     (clk),
        .rst     (rst),
        .mst_req (mst_req),
        .mst_rsp (mst_rsp),
        .slv_req (slv_req),
        .slv_rsp (slv_rsp)
    );

    xbar_slave_model u_sram (.clk(clk), .rst(rst), .tag(tag_sram), .seed_init(32'h11784b12 ^ 1),
        .req(slv_req[0]), .rsp(slv_rsp[0]));
    xbar_slave_model u_uart (.clk(clk), .rst(rst), .tag(tag_uart), .seed_init(32'h11784b12 ^ 2),
        .req(slv_req[1]), .rsp(slv_rsp[1]));
    xbar_slave_model u_clint (.clk(clk), .rst(rst), .tag(tag_clint), .seed_init(32'h11784b12 ^ 4),
        .req(slv_req[2]), .rsp(slv_rsp[2]));

    for (genvar k = 0; k < 3; k++) begin : g_bits
        assign slv_aw[k]  = slv_req[k].awvalid | slv_req[k].wvalid;
        assign slv_any[k] = slv_req[k].awvalid | slv_req[k].wvalid | slv_req[k].arvalid;

        // addresses and write data reach every port unchanged
        a_bcast: assert property (@(posedge clk) disable iff (rst)
            ({slv_req[k].araddr, slv_req[k].awaddr, slv_req[k].wdata, slv_req[k].wstrb} ==
             {mst_req.araddr, mst_req.awaddr, mst_req.wdata, mst_req.wstrb}))
            else begin
                errors = errors + 1;
                $display("Mismatch %s port %0d payload expected %h actual %h", test_name, k,
                         $sampled({mst_req.araddr, mst_req.awaddr, mst_req.wdata,
                                   mst_req.wstrb}),
                         $sampled({slv_req[k].araddr, slv_req[k].awaddr, slv_req[k].wdata,
                                   slv_req[k].wstrb}));
            end
    end

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // port index as the address map defines it
    function automatic int slave_of(input logic [31:0] addr);
        if (addr == `XBAR_UART_BASE) return 1;
        if (addr == `XBAR_CLINT_BASE || addr == `XBAR_CLINT_BASE + 4) return 2;
        return 0;
    endfunction

    function automatic logic [31:0] tag_of(input int k);
        if (k == 1) return tag_uart;
        if (k == 2) return tag_clint;
        return tag_sram;
    endfunction

    a_quiet: assert property (@(posedge clk) disable iff (rst)
        !req_seen |-> !(mst_rsp.rvalid || mst_rsp.bvalid || |slv_any))
        else begin
            errors = errors + 1;
            $display("valid raised before any request");
        end

    a_rdata: assert property (@(posedge clk) disable iff (rst)
        (mst_rsp.rvalid && mst_req.rready) |-> (mst_rsp.rdata == exp_rdata))
        else begin
            errors = errors + 1;
            $display("Mismatch %s expected %h actual %h", test_name,
                     $sampled(exp_rdata), $sampled(mst_rsp.rdata));
        end

    a_rresp: assert property (@(posedge clk) disable iff (rst)
        (mst_rsp.rvalid && mst_req.rready) |-> (mst_rsp.rresp == 2'b00))
        else begin
            errors = errors + 1;
            $display("Mismatch %s rresp expected 0 actual %0d", test_name,
                     $sampled(mst_rsp.rresp));
        end

    a_bresp: assert property (@(posedge clk) disable iff (rst)
        (mst_rsp.bvalid && mst_req.bready) |-> (mst_rsp.bresp == 2'b00))
        else begin
            errors = errors + 1;
            $display("Mismatch %s bresp expected 0 actual %0d", test_name,
                     $sampled(mst_rsp.bresp));
        end

    a_wr_route: assert property (@(posedge clk) disable iff (rst)
        (|slv_aw) |-> (slv_aw == 3'(1 << exp_wr_slave)))
        else begin
            errors = errors + 1;
            $display("Mismatch %s write port expected %b actual %b", test_name,
                     3'(1 << exp_wr_slave), $sampled(slv_aw));
        end

    a_rd_first: assert property (@(posedge clk) disable iff (rst)
        (|slv_aw) |-> !rd_pend)
        else begin
            errors = errors + 1;
            $display("%s: write reached a slave while the read was open", test_name);
        end

    a_r_hold: assert property (@(posedge clk) disable iff (rst)
        (mst_rsp.rvalid && !mst_req.rready) |=>
        (mst_rsp.rvalid && $stable(mst_rsp.rdata) && $stable(mst_rsp.rresp)))
        else begin
            errors = errors + 1;
            $display("%s: read response changed under back-pressure", test_name);
        end

    a_b_hold: assert property (@(posedge clk) disable iff (rst)
        (mst_rsp.bvalid && !mst_req.bready) |=> (mst_rsp.bvalid && $stable(mst_rsp.bresp)))
        else begin
            errors = errors + 1;
            $display("%s: write response changed under back-pressure", test_name);
        end

    a_one_rsp: assert property (@(posedge clk) disable iff (rst)
        !(mst_rsp.rvalid && mst_rsp.bvalid))
        else begin
            errors = errors + 1;
            $display("%s: rvalid and bvalid high together", test_name);
        end

    a_no_orphan: assert property (@(posedge clk) disable iff (rst)
        (mst_rsp.rvalid |-> rd_pend) and (mst_rsp.bvalid |-> wr_pend))
        else begin
            errors = errors + 1;
            $display("%s: response without an open request", test_name);
        end

    task automatic wait_ar();
        do @(posedge clk); while (!mst_rsp.arready);
        mst_req.arvalid <= 1'b0;
    endtask

    task automatic collect_r();
        int d;
        d = $random(seed) & 3;
        do @(posedge clk); while (!mst_rsp.rvalid);
        repeat (d) @(posedge clk); // hold rready low a while
        mst_req.rready <= 1'b1;
        @(posedge clk);
        mst_req.rready <= 1'b0;
        rd_pend        <= 1'b0;
    endtask

    task automatic wait_aw();
        do @(posedge clk); while (!(mst_rsp.awready && mst_rsp.wready));
        mst_req.awvalid <= 1'b0;
        mst_req.wvalid  <= 1'b0;
    endtask

    task automatic collect_b();
        int d;
        d = $random(seed) & 3;
        do @(posedge clk); while (!mst_rsp.bvalid);
        repeat (d) @(posedge clk);
        mst_req.bready <= 1'b1;
        @(posedge clk);
        mst_req.bready <= 1'b0;
        wr_pend        <= 1'b0;
    endtask

    task automatic read_txn(input logic [31:0] addr, input string name);
        int k;
        k = slave_of(addr);
        test_name = name;
        exp_rdata = store_m[k] ^ tag_of(k);
        @(posedge clk);
        mst_req.araddr  <= addr;
        mst_req.arvalid <= 1'b1;
        rd_pend         <= 1'b1;
        req_seen        <= 1'b1;
        wait_ar();
        collect_r();
        txns++;
    endtask

    task automatic write_txn(input logic [31:0] addr, input logic [31:0] data,
                             input string name);
        test_name    = name;
        exp_wr_slave = slave_of(addr);
        @(posedge clk);
        mst_req.awaddr  <= addr;
        mst_req.wdata   <= data;
        mst_req.wstrb   <= 4'hf;
        mst_req.awvalid <= 1'b1;
        mst_req.wvalid  <= 1'b1;
        wr_pend         <= 1'b1;
        req_seen        <= 1'b1;
        wait_aw();
        collect_b();
        store_m[exp_wr_slave] = data;
        txns++;
    endtask

    // read and write raised on the same edge
    task automatic both_txn(input logic [31:0] raddr, input logic [31:0] waddr,
                            input logic [31:0] data, input string name);
        int k;
        k = slave_of(raddr);
        test_name    = name;
        exp_rdata    = store_m[k] ^ tag_of(k);
        exp_wr_slave = slave_of(waddr);
        @(posedge clk);
        mst_req.araddr  <= raddr;
        mst_req.arvalid <= 1'b1;
        mst_req.awaddr  <= waddr;
        mst_req.wdata   <= data;
        mst_req.wstrb   <= 4'hf;
        mst_req.awvalid <= 1'b1;
        mst_req.wvalid  <= 1'b1;
        rd_pend         <= 1'b1;
        wr_pend         <= 1'b1;
        req_seen        <= 1'b1;
        wait_ar();
        collect_r();
        wait_aw();
        collect_b();
        store_m[exp_wr_slave] = data;
        txns += 2;
    endtask

    function automatic logic [31:0] pick_addr();
        case ($random(seed) & 3)
            0: return `XBAR_UART_BASE;
            1: return `XBAR_CLINT_BASE;
            2: return `XBAR_CLINT_BASE + 4;
            default: return $random(seed);
        endcase
    endfunction

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, %0d transactions done", cycles, txns);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        logic [31:0] a;
        logic [31:0] d;
        seed      = 32'h11784b12;
        errors    = 0;
        txns      = 0;
        cycles    = 0;
        test_name = "reset";
        exp_rdata = '0;
        exp_wr_slave = 0;
        for (int k = 0; k < 3; k++) store_m[k] = '0;
        mst_req  = '0;
        rd_pend  = 1'b0;
        wr_pend  = 1'b0;
        req_seen = 1'b0;
        rst      = 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        repeat (3) @(posedge clk); // idle with no request

        read_txn(`XBAR_UART_BASE, "read_uart");
        read_txn(`XBAR_CLINT_BASE, "read_clint");
        read_txn(`XBAR_CLINT_BASE + 4, "read_clint_hi");
        read_txn(32'h8000_0000, "read_sram");
        write_txn(`XBAR_UART_BASE, 32'h1234_5678, "write_uart");
        read_txn(`XBAR_UART_BASE, "readback_uart");
        write_txn(`XBAR_CLINT_BASE + 4, 32'hdead_beef, "write_clint");
        read_txn(`XBAR_CLINT_BASE, "readback_clint");
        write_txn(32'h0000_1000, 32'hcafe_f00d, "write_sram");
        read_txn(32'h0000_2000, "readback_sram");
        both_txn(`XBAR_UART_BASE, `XBAR_UART_BASE, 32'h0bad_cafe, "both_same");
        both_txn(`XBAR_CLINT_BASE, 32'h4000_0000, 32'h7777_1111, "both_split");

        for (int i = 0; i < 50; i++) begin
            a = pick_addr();
            d = $random(seed);
            case ($random(seed) & 3)
                0: write_txn(a, d, "rand_write");
                1: both_txn(pick_addr(), a, d, "rand_both");
                default: read_txn(a, "rand_read");
            endcase
        end

        repeat (4) @(posedge clk);
        $display("transactions %0d, errors %0d, cycles %0d", txns, errors, cycles);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== sim/xbar_slave_model.sv ====
`timescale 1ns/1ps

module xbar_slave_model (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [31:0]             tag,
    input  logic [31:0]             seed_init,
    input  xbar_pkg::axi_lite_req_t req,
    output xbar_pkg::axi_lite_rsp_t rsp
);
    import xbar_pkg::*;

    logic [31:0] store;  // the one word
    logic [1:0]  rd_wait;
    logic [1:0]  wr_wait;
    integer      seed;

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            rsp     <= '0;
            store   <= '0;
            rd_wait <= '0;
            wr_wait <= '0;
            seed = seed_init;
        end else begin
            // read side
            if (rsp.rvalid) begin
                if (req.rready) rsp.rvalid <= 1'b0;
            end else if (rsp.arready && req.arvalid) begin
                rsp.arready <= 1'b0;
                rsp.rvalid  <= 1'b1;
                rsp.rdata   <= store ^ tag;
                rsp.rresp   <= 2'b00;
            end else if (req.arvalid && !rsp.arready) begin
                if (rd_wait == 0) begin
                    rsp.arready <= 1'b1;
                    rd_wait     <= $random(seed) & 3; // delay for the next one
                end else begin
                    rd_wait <= rd_wait - 1;
                end
            end
            // write side accepts aw and w together
            if (rsp.bvalid) begin
                if (req.bready) rsp.bvalid <= 1'b0;
            end else if (rsp.awready && req.awvalid && req.wvalid) begin
                rsp.awready <= 1'b0;
                rsp.wready  <= 1'b0;
                rsp.bvalid  <= 1'b1;
                rsp.bresp   <= 2'b00;
                for (int b = 0; b < 4; b++) begin
                    if (req.wstrb[b]) store[b*8 +: 8] <= req.wdata[b*8 +: 8];
                end
            end else if (req.awvalid && req.wvalid && !rsp.awready) begin
                if (wr_wait == 0) begin
                    rsp.awready <= 1'b1;
                    rsp.wready  <= 1'b1;
                    wr_wait     <= $random(seed) & 3;
                end else begin
                    wr_wait <= wr_wait - 1;
                end
            end
        end
    end

endmodule
